/* filelist.f */
+incdir+design
design/avmm_wr_pkg.sv
design/burst_len_fifo.sv
design/wr_burst_tracker.sv
design/wr_ack_burst_to_word.sv
design/avmm_wr_ack_bridge.sv
tb/tb_avmm_wr_ack_bridge.sv

/* Makefile */
# Verilator build for the write-acknowledge bridge

VERILATOR  ?= verilator
TOP        := tb_avmm_wr_ack_bridge
DUT_TOP    := avmm_wr_ack_bridge
FILELIST   := filelist.f
VFLAGS     := -sv --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

SRCS := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation of $(DUT_TOP) passed"; \
	else \
		echo "Simulation of $(DUT_TOP) failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_avmm_wr_ack_bridge.sv */
// Write-acknowledge bridge testbench with kernel and memory models, reference counts, watchdog
`timescale 1ns/1ps
`include "avmm_wr_consts.svh"

module tb_avmm_wr_ack_bridge;

    localparam int NUM_RAND_BURSTS = 300;
    // Directed bursts are three timing bursts, a full FIFO and one held burst
    localparam int NUM_BURSTS = NUM_RAND_BURSTS + 3 + `BURST_FIFO_DEPTH + 1;
    localparam int CYCLE_LIMIT = NUM_BURSTS * 40;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      kernel_write;
    avmm_wr_pkg::avmm_wr_cmd_t kernel_cmd;
    logic                      kernel_waitrequest;
    logic                      kernel_writeack;
    logic                      mem_write;
    avmm_wr_pkg::avmm_wr_cmd_t mem_cmd;
    logic                      mem_waitrequest;
    logic                      mem_writeresponsevalid;

    integer seed = 96;

    // Memory model controls
    bit wait_random = 1'b0;
    bit resp_auto   = 1'b0;
    int resp_delay  = 0;

    // Reference model state
    avmm_wr_pkg::avmm_wr_cmd_t exp_beats[$];
    int resp_queue[$];
    int mon_beats_left  = 0;
    int mon_len         = 0;
    int words_accepted  = 0;
    int words_responded = 0;
    int acks_seen       = 0;

    always #2 clk = ~clk;

    avmm_wr_ack_bridge i_dut (
        .clk                    (clk),
        .reset                  (reset),
        .kernel_write           (kernel_write),
        .kernel_cmd             (kernel_cmd),
        .kernel_waitrequest     (kernel_waitrequest),
        .kernel_writeack        (kernel_writeack),
        .mem_write              (mem_write),
        .mem_cmd                (mem_cmd),
        .mem_waitrequest        (mem_waitrequest),
        .mem_writeresponsevalid (mem_writeresponsevalid)
    );

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string test_name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %0h actual %0h", test_name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic avmm_wr_pkg::avmm_wr_cmd_t random_beat(input int len);
        avmm_wr_pkg::avmm_wr_cmd_t beat;
        beat.address    = avmm_wr_pkg::avmm_addr_t'($random(seed));
        beat.writedata  = {$random(seed), $random(seed)};
        beat.byteenable = avmm_wr_pkg::avmm_be_t'($random(seed));
        // Same count on every beat although only the first one counts
        beat.burstcount = avmm_wr_pkg::burst_cnt_t'(len);
        return beat;
    endfunction

    // Pop the oldest completed burst and answer it this cycle
    task automatic give_response();
        if (resp_queue.size() == 0)
        begin
            $display("Response requested with no completed burst outstanding");
            stop_on_error();
        end
        else
        begin
            words_responded += resp_queue.pop_front();
            mem_writeresponsevalid = 1'b1;
        end
    endtask

    // Memory side inputs for one cycle
    task automatic memory_step();
        mem_writeresponsevalid = 1'b0;
        if (wait_random)
            mem_waitrequest = (($random(seed) & 3) == 0);
        else
            mem_waitrequest = 1'b0;
        if (resp_auto)
        begin
            if (resp_delay > 0)
                resp_delay--;
            else if (resp_queue.size() > 0)
            begin
                give_response();
                // Half the time the next response may follow right away
                if (($random(seed) & 1) == 0)
                    resp_delay = 0;
                else
                    resp_delay = $random(seed) & 7;
            end
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        memory_step();
    endtask

    // Hold one beat until the kernel side sees it accepted
    task automatic drive_beat(input avmm_wr_pkg::avmm_wr_cmd_t beat);
        logic accepted;
        exp_beats.push_back(beat);
        kernel_write = 1'b1;
        kernel_cmd   = beat;
        accepted     = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = !kernel_waitrequest;
            next_cycle();
        end
    endtask

    task automatic send_burst(input int len);
        for (int i = 0; i < len; i++)
            drive_beat(random_beat(len));
        kernel_write = 1'b0;
    endtask

    // Beat order and burst ends as memory sees them
    task automatic record_accepted_beat();
        if (exp_beats.size() == 0)
        begin
            $display("Memory accepted a beat that the kernel never drove");
            stop_on_error();
        end
        else
        begin
            check_value("beat_order", exp_beats.pop_front(), mem_cmd);
            words_accepted++;
            if (mon_beats_left == 0)
            begin
                mon_len        = int'(mem_cmd.burstcount);
                mon_beats_left = mon_len;
            end
            mon_beats_left--;
            if (mon_beats_left == 0)
                resp_queue.push_back(mon_len);
        end
    endtask

    // Sampled mid-cycle where all DUT outputs are settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (mem_write && !mem_waitrequest)
                record_accepted_beat();
            if (kernel_writeack)
            begin
                acks_seen++;
                if (acks_seen > words_responded)
                begin
                    $display("Acknowledge count %0d is ahead of the %0d responded words",
                             acks_seen, words_responded);
                    stop_on_error();
                end
            end
        end
    end

    // With the pipeline empty one response gives acks from t+2 to t+len+1
    task automatic single_burst_timing(input int len);
        send_burst(len);
        next_cycle();
        next_cycle();
        give_response();
        for (int k = 0; k <= len + 3; k++)
        begin
            @(negedge clk);
            check_value($sformatf("single_ack_len%0d_cycle%0d", len, k),
                        (k >= 2) && (k <= len + 1), kernel_writeack);
            next_cycle();
        end
    endtask

    // Fill the FIFO, then the next burst start must be held off
    task automatic full_fifo_hold();
        for (int i = 0; i < `BURST_FIFO_DEPTH; i++)
            send_burst(2);
        drive_beat_held: begin
            exp_beats.push_back(random_beat(1));
            kernel_write = 1'b1;
            kernel_cmd   = exp_beats[exp_beats.size() - 1];
        end
        repeat (3)
        begin
            @(negedge clk);
            check_value("full_hold_waitreq", 1, kernel_waitrequest);
            check_value("full_hold_mem_write", 0, mem_write);
            next_cycle();
        end
        give_response();
        @(negedge clk);
        check_value("full_hold_resp_cycle", 1, kernel_waitrequest);
        next_cycle();
        // The held beat goes through once one entry is freed
        @(negedge clk);
        check_value("full_release", 0, kernel_waitrequest);
        next_cycle();
        kernel_write = 1'b0;
    endtask

    // Answer everything, let acks run out, then compare the ack total
    task automatic drain_all();
        resp_auto = 1'b1;
        while (exp_beats.size() != 0 || mon_beats_left != 0 || resp_queue.size() != 0)
            next_cycle();
        // Last response reaches the ack output two cycles later
        next_cycle();
        next_cycle();
        @(negedge clk);
        while (kernel_writeack)
        begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        check_value("ack_total", words_accepted, acks_seen);
    endtask

    initial
    begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        stop_on_error();
    end

    initial
    begin
        int gap;
        reset                  = 1'b1;
        kernel_write           = 1'b0;
        kernel_cmd             = '0;
        mem_waitrequest        = 1'b0;
        mem_writeresponsevalid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle outputs straight after reset
        @(negedge clk);
        check_value("reset_writeack", 0, kernel_writeack);
        check_value("reset_waitrequest", 0, kernel_waitrequest);
        next_cycle();

        single_burst_timing(1);
        single_burst_timing(5);
        single_burst_timing(16);

        full_fifo_hold();
        drain_all();

        // Random bursts, random back-pressure and response delays
        wait_random = 1'b1;
        resp_auto   = 1'b1;
        for (int b = 0; b < NUM_RAND_BURSTS; b++)
        begin
            send_burst(1 + ($unsigned($random(seed)) % 16));
            gap = $random(seed) & 3;
            repeat (gap) next_cycle();
        end
        drain_all();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_avmm_wr_ack_bridge

/* design/avmm_wr_ack_bridge.sv */
// Top level write-acknowledge bridge with command pass-through, tracker, FIFO and converter
`timescale 1ns/1ps

module avmm_wr_ack_bridge
(
    input  logic                      clk,
    input  logic                      reset,

    // Kernel side
    input  logic                      kernel_write,
    input  avmm_wr_pkg::avmm_wr_cmd_t kernel_cmd,
    output logic                      kernel_waitrequest,
    output logic                      kernel_writeack,

    // Memory side
    output logic                      mem_write,
    output avmm_wr_pkg::avmm_wr_cmd_t mem_cmd,
    input  logic                      mem_waitrequest,
    input  logic                      mem_writeresponsevalid
);

    logic                    tracker_hold;
    logic                    fifo_push;
    avmm_wr_pkg::burst_cnt_t fifo_push_count;
    avmm_wr_pkg::burst_cnt_t fifo_pop_count;
    logic                    fifo_full;

    // Commands go straight through and the hold masks the strobe
    assign mem_cmd   = kernel_cmd;
    assign mem_write = kernel_write && !tracker_hold;

    // Memory back-pressure passes in the same cycle
    assign kernel_waitrequest = mem_waitrequest || tracker_hold;

    wr_burst_tracker i_tracker (
        .clk         (clk),
        .reset       (reset),
        .write       (kernel_write),
        .waitrequest (mem_waitrequest),
        .burstcount  (kernel_cmd.burstcount),
        .fifo_full   (fifo_full),
        .hold        (tracker_hold),
        .push        (fifo_push),
        .push_count  (fifo_push_count)
    );

    // One entry per burst still waiting for its response
    burst_len_fifo i_burst_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (fifo_push),
        .push_count (fifo_push_count),
        .pop        (mem_writeresponsevalid),
        .pop_count  (fifo_pop_count),
        .full       (fifo_full),
        .empty      ()
    );

    // Popped count lines up with the response strobe
    wr_ack_burst_to_word i_ack_conv (
        .clk       (clk),
        .reset     (reset),
        .burstcnt  (fifo_pop_count),
        .burst_ack (mem_writeresponsevalid),
        .word_ack  (kernel_writeack)
    );

    // Two cycle response to first acknowledge latency
    a_ack_latency: assert property (@(posedge clk) disable iff (reset)
        mem_writeresponsevalid |-> ##2 kernel_writeack);

endmodule : avmm_wr_ack_bridge

/* design/wr_ack_burst_to_word.sv */
// Converter from per-burst write response to per-word acknowledge cycles
`timescale 1ns/1ps

module wr_ack_burst_to_word
(
    input  logic                    clk,
    input  logic                    reset,

    input  avmm_wr_pkg::burst_cnt_t burstcnt,
    input  logic                    burst_ack,

    output logic                    word_ack
);

    // Registered response and its count
    logic                    burst_ack_d;
    avmm_wr_pkg::burst_cnt_t burstcnt_d;

    // Words acknowledged by memory but not yet signalled
    avmm_wr_pkg::ack_cnt_t   pend_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_ack_d <= 1'b0;
        end
        else
        begin
            burst_ack_d <= burst_ack;
        end
    end

    // Count is only looked at alongside burst_ack_d
    always_ff @(posedge clk)
    begin
        burstcnt_d <= burstcnt;
    end

    // Pending word counter
    // Empty counter just loads, no acknowledge is going out
    // New burst while busy adds its count and drops the word sent now
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pend_cnt <= '0;
        end
        else if (burst_ack_d && (pend_cnt == '0))
        begin
            pend_cnt <= avmm_wr_pkg::ack_cnt_t'(burstcnt_d);
        end
        else if (burst_ack_d)
        begin
            pend_cnt <= pend_cnt + avmm_wr_pkg::ack_cnt_t'(burstcnt_d)
                        - avmm_wr_pkg::ack_cnt_t'(word_ack);
        end
        else if (word_ack)
        begin
            pend_cnt <= pend_cnt - avmm_wr_pkg::ack_cnt_t'(1);
        end
    end

    // One acknowledge per cycle while words remain
    always_comb
    begin
        word_ack = (pend_cnt != '0);
    end

    // After a response the counter holds at least that burst, else it wrapped
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        burst_ack_d |=> (pend_cnt >= avmm_wr_pkg::ack_cnt_t'($past(burstcnt_d))));

endmodule : wr_ack_burst_to_word

/* design/wr_burst_tracker.sv */
// Write burst tracker FSM with burst start detection, count push and full FIFO hold
`timescale 1ns/1ps

module wr_burst_tracker
(
    input  logic                    clk,
    input  logic                    reset,

    // Kernel side strobe and memory side back-pressure
    input  logic                    write,
    input  logic                    waitrequest,
    input  avmm_wr_pkg::burst_cnt_t burstcount,

    // Burst length FIFO interface
    input  logic                    fifo_full,
    output logic                    hold,
    output logic                    push,
    output avmm_wr_pkg::burst_cnt_t push_count
);

    avmm_wr_pkg::tracker_state_t state;

    // Beats still expected in the current burst
    avmm_wr_pkg::burst_cnt_t beats_left;

    // A beat passes only when memory is ready and no hold is in force
    logic beat_accepted;

    // Hold only between bursts and never in the middle of one
    // Same cycle as the full flag so no burst start slips past
    assign hold = (state == avmm_wr_pkg::BURST_IDLE) && fifo_full;

    assign beat_accepted = write && !waitrequest && !hold;

    // First accepted beat of a burst records its length
    assign push       = (state == avmm_wr_pkg::BURST_IDLE) && beat_accepted;
    assign push_count = burstcount;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= avmm_wr_pkg::BURST_IDLE;
            beats_left <= '0;
        end
        else
        begin
            case (state)
                avmm_wr_pkg::BURST_IDLE:
                begin
                    // Single word bursts end on their only beat
                    if (beat_accepted && (burstcount > avmm_wr_pkg::burst_cnt_t'(1)))
                    begin
                        state      <= avmm_wr_pkg::BURST_ACTIVE;
                        beats_left <= burstcount - 1'b1;
                    end
                end

                avmm_wr_pkg::BURST_ACTIVE:
                begin
                    if (beat_accepted)
                    begin
                        beats_left <= beats_left - 1'b1;
                        // Last beat closes the burst
                        if (beats_left == avmm_wr_pkg::burst_cnt_t'(1))
                        begin
                            state <= avmm_wr_pkg::BURST_IDLE;
                        end
                    end
                end

                default:
                begin
                    state      <= avmm_wr_pkg::BURST_IDLE;
                    beats_left <= '0;
                end
            endcase
        end
    end

    // A zero length burst would never close and never be acknowledged
    a_burst_nonzero: assert property (@(posedge clk) disable iff (reset)
        push |-> (burstcount != '0));

endmodule : wr_burst_tracker

/* design/burst_len_fifo.sv */
// Show-ahead FIFO of burst counts waiting for a write response
`timescale 1ns/1ps
`include "avmm_wr_consts.svh"

module burst_len_fifo
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    push,
    input  avmm_wr_pkg::burst_cnt_t push_count,

    input  logic                    pop,
    output avmm_wr_pkg::burst_cnt_t pop_count,

    output logic                    full,
    output logic                    empty
);

    localparam int DEPTH = `BURST_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    // One extra bit so a full buffer is distinct from an empty one
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, no reset on payload
    avmm_wr_pkg::burst_cnt_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;

    // Qualified strobes
    logic wr_en;
    logic rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    // Write side
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= push_count;
        end
    end

    // Pointers wrap explicitly, depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            occupancy <= '0;
        end
        else
        begin
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Oldest entry always visible, valid in the cycle of the pop
    assign pop_count = mem[rd_ptr];

    assign full  = (occupancy == CNT_W'(DEPTH));
    assign empty = (occupancy == '0);

    // Memory must never answer a burst that was not recorded
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

    // Tracker hold must keep bursts out while the FIFO is full
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule : burst_len_fifo

/* design/avmm_wr_pkg.sv */
// Package with bridge vector typedefs, write command struct and tracker state enum
`include "avmm_wr_consts.svh"

package avmm_wr_pkg;

    // Vectors with a meaning of their own
    typedef logic [`AVMM_ADDR_WIDTH-1:0]     avmm_addr_t;
    typedef logic [`AVMM_DATA_WIDTH-1:0]     avmm_data_t;
    typedef logic [`AVMM_BE_WIDTH-1:0]       avmm_be_t;
    typedef logic [`AVMM_BURSTCNT_WIDTH-1:0] burst_cnt_t;
    typedef logic [`AVMM_ACK_CNT_WIDTH-1:0]  ack_cnt_t;

    // One write beat as seen on the Avalon-MM bus
    // Burstcount only matters on the first beat of a burst
    typedef struct packed {
        avmm_addr_t address;
        avmm_data_t writedata;
        avmm_be_t   byteenable;
        burst_cnt_t burstcount;
    } avmm_wr_cmd_t;

    // Burst tracker FSM
    typedef enum logic {
        BURST_IDLE,
        BURST_ACTIVE
    } tracker_state_t;

endpackage : avmm_wr_pkg

/* design/avmm_wr_consts.svh */
// Width and depth constants for the write-acknowledge bridge
`ifndef AVMM_WR_CONSTS_SVH
`define AVMM_WR_CONSTS_SVH

// Word address into local memory
`define AVMM_ADDR_WIDTH 26

// Write data bus width in bits
`define AVMM_DATA_WIDTH 64

// Byte enable width follows the data width
`define AVMM_BE_WIDTH (`AVMM_DATA_WIDTH / 8)

// Burst count field, bursts of 1 to 16 words
`define AVMM_BURSTCNT_WIDTH 5

// Pending word counter in the acknowledge converter
// Wide enough for a full FIFO of maximum bursts plus margin
`define AVMM_ACK_CNT_WIDTH 10

// Most bursts that may wait for a memory response
`define BURST_FIFO_DEPTH 8

`endif
